//--- Makefile
# Verilator build and run of the fetch unit testbench
VERILATOR ?= verilator
TOP       ?= tb_l1i_fetch
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

# the run is piped into the log, so the grep decides pass or fail
sim:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/1ps \
		-f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/predecode.sv
verilog/l1i_arrays.sv
verilog/fetch_queue.sv
verilog/fetch_ctrl.sv
verilog/l1i_fetch.sv
testbench/tb_l1i_fetch.sv

//--- testbench/tb_l1i_fetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_l1i_fetch;

   localparam WAIT_LIMIT = 3000;
   localparam IMG_WORDS = 64;     // program fills the whole 256 byte cache

   logic                    clk = 1'b0;
   logic                    reset = 1'b1;
   logic                    restart_valid = 1'b0;
   logic [`ADDR_W-1:0]      restart_pc = '0;
   logic                    flush_req = 1'b0;
   logic                    mem_rsp_valid = 1'b0;
   logic [`L1I_CL_BITS-1:0] mem_rsp_load_data = '0;
   logic                    insn_ack = 1'b0;
   logic                    restart_ack;
   logic                    flush_complete;
   logic                    mem_req_valid;
   logic [`ADDR_W-1:0]      mem_req_addr;
   logic                    insn_valid;
   logic [`INSN_W-1:0]      insn_data;
   logic [`ADDR_W-1:0]      insn_pc;
   logic                    insn_pred;
   logic [`ADDR_W-1:0]      insn_pred_target;

   logic [`INSN_W-1:0]      image [IMG_WORDS];
   logic                    ack_enable = 1'b0;
   logic                    ctl_pending = 1'b1;   // restart or flush in flight
   logic [`ADDR_W-1:0]      exp_pc;
   logic [`INSN_W-1:0]      exp_word;
   logic                    exp_pred;
   logic [`ADDR_W-1:0]      exp_target;
   int                      pop_count;
   int                      req_count;
   logic [`ADDR_W-1:0]      last_req_addr;
   logic                    req_open;
   logic [15:0]             line_seen;            // lines fetched since last flush
   logic                    rsp_pending;
   int                      rsp_delay;
   logic [`ADDR_W-1:0]      rsp_addr;

   l1i_fetch dut (.*);

   always #5 clk = ~clk;

   function automatic logic is_redirect(input logic [`INSN_W-1:0] w);
      return (w[31:26] == 6'd2) || (w[31:26] == 6'd3) ||
             ((w[31:26] == 6'd4) && (w[25:16] == 10'd0));
   endfunction

   // expected successor of a fetched word
   function automatic logic [`ADDR_W-1:0] next_pc(input logic [`ADDR_W-1:0] pc,
                                                  input logic [`INSN_W-1:0] w);
      logic [`ADDR_W-1:0] seq;
      seq = pc + 32'd4;
      if ((w[31:26] == 6'd2) || (w[31:26] == 6'd3))
      begin
         return {pc[31:28], w[25:0], 2'b00};
      end
      else if (is_redirect(w))
      begin
         return seq + {{14{w[15]}}, w[15:0], 2'b00};
      end
      return seq;
   endfunction

   function automatic logic [`INSN_W-1:0] jump_word(input logic [5:0] op,
                                                    input logic [`ADDR_W-1:0] tgt);
      return {op, tgt[27:2]};
   endfunction

   function automatic logic [`INSN_W-1:0] beq_word(input logic [`ADDR_W-1:0] pc,
                                                   input logic [`ADDR_W-1:0] tgt);
      logic [`ADDR_W-1:0] diff;
      diff = tgt - (pc + 32'd4);
      return {6'd4, 10'd0, diff[17:2]};   // beq $0,$0
   endfunction

   // four words of a line stored big-endian
   function automatic logic [`L1I_CL_BITS-1:0] line_data(input logic [`ADDR_W-1:0] addr);
      logic [`L1I_CL_BITS-1:0] d;
      logic [`INSN_W-1:0]      w;
      int                      k;
      for (k = 0; k < 4; k++)
      begin
         w = image[{addr[7:4], k[1:0]}];
         d[k*32 +: 32] = {w[7:0], w[15:8], w[23:16], w[31:24]};
      end
      return d;
   endfunction

   task automatic place_word(input logic [`ADDR_W-1:0] addr, input logic [`INSN_W-1:0] w);
      image[addr[7:2]] = w;
   endtask

   task automatic build_image();
      logic [`INSN_W-1:0] w;
      int                 i;
      for (i = 0; i < IMG_WORDS; i++)
      begin
         w = $urandom();
         w[31:26] = 6'd0;   // special-opcode alu word
         image[i] = w;
      end
      place_word(32'h0c, {6'd4, 5'd1, 5'd0, 16'd2});        // conditional branch not predicted
      place_word(32'h20, jump_word(6'd2, 32'h40));
      place_word(32'h78, beq_word(32'h78, 32'h40));         // loop back
      place_word(32'h90, jump_word(6'd3, 32'hc0));
      place_word(32'hc4, {6'd0, 5'd31, 15'd0, 6'd8});       // jr $ra stays sequential
      place_word(32'he0, beq_word(32'he0, 32'hf0));
      place_word(32'hfc, jump_word(6'd2, 32'h00));
   endtask

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic timeout_fail(input string what);
      $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   endtask

   task automatic do_restart(input logic [`ADDR_W-1:0] pc);
      int n;
      n = 0;
      @(posedge clk);
      ctl_pending = 1'b1;
      @(negedge clk);
      restart_valid = 1'b1;
      restart_pc = pc;
      @(negedge clk);
      restart_valid = 1'b0;
      while (!restart_ack && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (!restart_ack)
      begin
         timeout_fail("restart_ack");
      end
      @(posedge clk);        // walker picks up the new pc here
      ctl_pending = 1'b0;
   endtask

   task automatic do_flush();
      int n;
      n = 0;
      @(posedge clk);
      ctl_pending = 1'b1;    // stays set until the next restart
      @(negedge clk);
      flush_req = 1'b1;
      @(negedge clk);
      flush_req = 1'b0;
      while (!flush_complete && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (!flush_complete)
      begin
         timeout_fail("flush_complete");
      end
   endtask

   task automatic wait_pops(input int count);
      int target;
      int n;
      target = pop_count + count;
      n = 0;
      while ((pop_count < target) && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (pop_count < target)
      begin
         timeout_fail("popped instructions");
      end
   endtask

   task automatic wait_request(input int snap);
      int n;
      n = 0;
      while ((req_count == snap) && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (req_count == snap)
      begin
         timeout_fail("a memory request after flush");
      end
   endtask

   // consumer acks only what is visible
   always @(negedge clk)
   begin
      if (reset || !ack_enable || ctl_pending)
      begin
         insn_ack <= 1'b0;
      end
      else
      begin
         insn_ack <= insn_valid && (($urandom % 4) != 0);
      end
   end

   // memory responder sends one line per request after a random delay
   always @(negedge clk)
   begin
      mem_rsp_valid <= 1'b0;
      if (reset)
      begin
         rsp_pending <= 1'b0;
      end
      else if (rsp_pending)
      begin
         if (rsp_delay == 0)
         begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_load_data <= line_data(rsp_addr);
            rsp_pending <= 1'b0;
         end
         else
         begin
            rsp_delay <= rsp_delay - 1;
         end
      end
      else if (mem_req_valid)
      begin
         rsp_pending <= 1'b1;
         rsp_addr <= mem_req_addr;
         rsp_delay <= $urandom % 8;
      end
   end

   assign exp_word = image[exp_pc[7:2]];
   assign exp_pred = is_redirect(exp_word);
   assign exp_target = next_pc(exp_pc, exp_word);

   // reference pc walker
   always @(posedge clk)
   begin
      if (reset)
      begin
         exp_pc <= '0;
         pop_count <= 0;
      end
      else if (restart_ack)
      begin
         exp_pc <= restart_pc;
      end
      else if (insn_valid && insn_ack)
      begin
         exp_pc <= exp_target;
         pop_count <= pop_count + 1;
      end
   end

   // refill traffic bookkeeping
   always @(posedge clk)
   begin
      if (reset)
      begin
         req_count <= 0;
         req_open <= 1'b0;
         line_seen <= '0;
         last_req_addr <= '0;
      end
      else
      begin
         if (mem_req_valid)
         begin
            req_open <= 1'b1;
            req_count <= req_count + 1;
            last_req_addr <= mem_req_addr;
            line_seen[mem_req_addr[7:4]] <= 1'b1;
         end
         else if (mem_rsp_valid)
         begin
            req_open <= 1'b0;
         end
         if (flush_complete)
         begin
            line_seen <= '0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      (insn_valid && insn_ack) |-> (insn_pc == exp_pc))
      else report_mismatch("popped pc differs from the reference walker");
   assert property (@(posedge clk) disable iff (reset)
      (insn_valid && insn_ack) |-> (insn_data == exp_word))
      else report_mismatch("popped instruction differs from the program image");
   assert property (@(posedge clk) disable iff (reset)
      (insn_valid && insn_ack) |-> (insn_pred == exp_pred))
      else report_mismatch("predicted-taken bit wrong");
   assert property (@(posedge clk) disable iff (reset)
      (insn_valid && insn_ack && exp_pred) |-> (insn_pred_target == exp_target))
      else report_mismatch("predicted target wrong");
   // head entry holds while nothing pops
   assert property (@(posedge clk) disable iff (reset)
      (insn_valid && !insn_ack && !ctl_pending) |=>
      (insn_valid && (insn_pc == $past(insn_pc)) && (insn_data == $past(insn_data)) &&
       (insn_pred == $past(insn_pred)) && (insn_pred_target == $past(insn_pred_target))))
      else report_mismatch("queue head changed without a pop");
   assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> ((mem_req_addr[3:0] == 4'd0) && (mem_req_addr < 32'h100)))
      else report_mismatch("memory request not line aligned or outside the program");
   assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !req_open)
      else report_mismatch("second memory request before the response");
   assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !line_seen[mem_req_addr[7:4]])
      else report_mismatch("refill requested for a line already cached");

   initial
   begin
      int snap;
      void'($urandom(32'h2bc5ab0a));
      build_image();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      assert (!insn_valid && !mem_req_valid && !restart_ack && !flush_complete)
         else report_mismatch("outputs not idle after reset");

      // sequential code, redirects and the cached loop
      @(posedge clk);
      ack_enable = 1'b1;
      do_restart(32'h00);
      wait_pops(80);

      // long stall so the queue fills
      @(posedge clk);
      ack_enable = 1'b0;
      repeat (40) @(negedge clk);
      @(posedge clk);
      ack_enable = 1'b1;
      wait_pops(30);

      // restart mid-stream into the jal / beq / j path
      do_restart(32'h80);
      wait_pops(40);

      // after a flush a cached address has to miss again
      do_flush();
      snap = req_count;
      do_restart(32'h40);
      wait_request(snap);
      assert (last_req_addr == 32'h40)
         else report_mismatch("first request after flush is not line 0x40");
      wait_pops(20);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_ctrl import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     restart_valid,
   input  logic [`ADDR_W-1:0]       restart_pc,
   input  logic                     flush_req,
   input  logic                     mem_rsp_valid,
   input  logic                     rd_valid,
   input  logic [`L1I_TAG_W-1:0]    rd_tag,
   input  logic [`L1I_CL_BITS-1:0]  rd_line,
   input  jump_t [3:0]              rd_cls,
   input  logic                     fq_full,
   output logic                     restart_ack,
   output logic                     flush_complete,
   output logic                     mem_req_valid,
   output logic [`ADDR_W-1:0]       mem_req_addr,
   output logic [`L1I_LG_SETS-1:0]  rd_idx,
   output logic                     inv_en,
   output logic [`L1I_LG_SETS-1:0]  inv_idx,
   output logic                     fq_clear,
   output logic                     fq_push,
   output logic [`INSN_W-1:0]       push_data,
   output logic [`ADDR_W-1:0]       push_pc,
   output logic                     push_pred,
   output logic [`ADDR_W-1:0]       push_target
);

   localparam IDX_LO = `L1I_LG_CL_BYTES;
   localparam IDX_HI = `L1I_LG_CL_BYTES + `L1I_LG_SETS;
   localparam WORD_BITS = `L1I_LG_CL_BYTES - 2;
   localparam SEXT_W = `ADDR_W - 18;

   state_t                  r_state, n_state;
   logic [`ADDR_W-1:0]      r_pc, n_pc;
   logic [`ADDR_W-1:0]      r_cache_pc, n_cache_pc;   // pc whose read returns now
   logic [`ADDR_W-1:0]      r_miss_pc, n_miss_pc;
   logic [`ADDR_W-1:0]      r_restart_pc;
   logic [`ADDR_W-1:0]      n_mem_req_addr;
   logic                    r_req, n_req;
   logic                    r_restart_req, n_restart_req;
   logic                    r_flush_req, n_flush_req;
   logic [`L1I_LG_SETS-1:0] r_flush_idx, n_flush_idx;
   logic                    n_restart_ack, n_flush_complete, n_mem_req_valid;
   logic                    t_accept;
   logic [WORD_BITS-1:0]    t_word_idx;
   logic [`INSN_W-1:0]      t_word;
   jump_t                   t_cls;
   logic                    t_tag_match, t_hit, t_miss, t_redirect;
   logic [`ADDR_W-1:0]      t_seq_pc, t_simm, t_target, t_restart_pc;

   // look at the line read last cycle
   always_comb
   begin
      t_word_idx = r_cache_pc[2 +: WORD_BITS];
      t_word = rd_line[t_word_idx*`INSN_W +: `INSN_W];
      t_cls = rd_cls[t_word_idx];
      t_tag_match = rd_valid && (rd_tag == r_cache_pc[`ADDR_W-1:IDX_HI]);
      t_hit = r_req && t_tag_match;
      t_miss = r_req && !t_tag_match;
      t_seq_pc = r_cache_pc + 'd4;
      t_simm = {{SEXT_W{t_word[15]}}, t_word[15:0], 2'b00};
      t_redirect = (t_cls != NOT_CFLOW);
      case (t_cls)
         IS_J, IS_JAL:
         begin
            t_target = {r_cache_pc[`ADDR_W-1:28], t_word[25:0], 2'b00};
         end
         IS_BR:
         begin
            t_target = t_seq_pc + t_simm;
         end
         default:
         begin
            t_target = t_seq_pc;
         end
      endcase
   end

   assign t_restart_pc = restart_valid ? restart_pc : r_restart_pc;
   assign push_data = t_word;
   assign push_pc = r_cache_pc;
   assign push_pred = t_redirect;
   assign push_target = t_target;

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_cache_pc = r_cache_pc;
      n_miss_pc = r_miss_pc;
      n_req = 1'b0;
      n_restart_req = r_restart_req | restart_valid;
      n_restart_ack = 1'b0;
      n_flush_req = r_flush_req | flush_req;
      n_flush_complete = 1'b0;
      n_flush_idx = r_flush_idx;
      n_mem_req_valid = 1'b0;
      n_mem_req_addr = mem_req_addr;
      rd_idx = '0;
      inv_en = 1'b0;
      inv_idx = r_flush_idx;
      fq_clear = 1'b0;
      fq_push = 1'b0;
      t_accept = 1'b0;
      case (r_state)
         IDLE:
         begin
            t_accept = 1'b1;
         end
         ACTIVE:
         begin
            rd_idx = r_pc[IDX_HI-1:IDX_LO];
            n_cache_pc = r_pc;
            n_req = 1'b1;
            n_pc = r_pc + 'd4;
            if (n_flush_req || n_restart_req)
            begin
               t_accept = 1'b1;
            end
            else if (t_miss)
            begin
               n_mem_req_valid = 1'b1;
               n_mem_req_addr = {r_cache_pc[`ADDR_W-1:IDX_LO], {IDX_LO{1'b0}}};
               n_miss_pc = r_cache_pc;
               n_pc = t_seq_pc;
               n_state = INJECT_RELOAD;
            end
            else if (t_hit && !fq_full)
            begin
               fq_push = 1'b1;
               if (t_redirect)
               begin
                  n_pc = t_target;
                  n_req = 1'b0;      // drop the sequential read in flight
               end
            end
            else if (t_hit)
            begin
               // queue full, re-read this pc later
               n_miss_pc = r_cache_pc;
               n_pc = t_seq_pc;
               n_state = WAIT_FOR_NOT_FULL;
            end
         end
         INJECT_RELOAD:
         begin
            if (mem_rsp_valid)
            begin
               n_state = RELOAD_TURNAROUND;
            end
         end
         RELOAD_TURNAROUND, WAIT_FOR_NOT_FULL:
         begin
            rd_idx = r_miss_pc[IDX_HI-1:IDX_LO];
            n_cache_pc = r_miss_pc;
            if (n_flush_req || n_restart_req)
            begin
               t_accept = 1'b1;
            end
            else if (!fq_full)
            begin
               n_req = 1'b1;
               n_state = ACTIVE;
            end
         end
         FLUSH_CACHE:
         begin
            inv_en = 1'b1;
            n_flush_idx = r_flush_idx + 1'b1;
            if (&r_flush_idx)
            begin
               n_flush_complete = 1'b1;
               n_state = IDLE;
            end
         end
         default:
         begin
            n_state = IDLE;
         end
      endcase

      // flush takes priority over restart
      if (t_accept && n_flush_req)
      begin
         n_flush_req = 1'b0;
         n_flush_idx = '0;
         n_req = 1'b0;
         fq_clear = 1'b1;
         n_state = FLUSH_CACHE;
      end
      else if (t_accept && n_restart_req)
      begin
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         n_pc = t_restart_pc;
         n_req = 1'b0;
         fq_clear = 1'b1;
         n_state = ACTIVE;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_req <= 1'b0;
         r_restart_req <= 1'b0;
         r_flush_req <= 1'b0;
         r_flush_idx <= '0;
         restart_ack <= 1'b0;
         flush_complete <= 1'b0;
         mem_req_valid <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_req <= n_req;
         r_restart_req <= n_restart_req;
         r_flush_req <= n_flush_req;
         r_flush_idx <= n_flush_idx;
         restart_ack <= n_restart_ack;
         flush_complete <= n_flush_complete;
         mem_req_valid <= n_mem_req_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_cache_pc <= n_cache_pc;
      r_miss_pc <= n_miss_pc;
      mem_req_addr <= n_mem_req_addr;   // also the refill address
      if (restart_valid)
      begin
         r_restart_pc <= restart_pc;
      end
   end

endmodule

//--- verilog/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and pc width
`define ADDR_W 32
`define INSN_W 32

// direct-mapped L1I geometry, 16 sets of 16 byte lines
`define L1I_LG_SETS 4
`define L1I_LG_CL_BYTES 4
`define L1I_CL_BITS (8 << `L1I_LG_CL_BYTES)

// whatever is left above the set index
`define L1I_TAG_W (`ADDR_W - `L1I_LG_SETS - `L1I_LG_CL_BYTES)

// fetch queue depth, 8 entries
`define LG_FQ_ENTRIES 3

`endif

//--- verilog/fetch_pkg.sv
package fetch_pkg;

   // predecode classes, only direct redirects are told apart
   typedef enum logic [1:0]
   {
      NOT_CFLOW = 2'd0,
      IS_J      = 2'd1,
      IS_JAL    = 2'd2,
      IS_BR     = 2'd3     // beq $0,$0
   } jump_t;

   // fetch FSM states
   typedef enum logic [2:0]
   {
      IDLE              = 3'd0,
      ACTIVE            = 3'd1,
      INJECT_RELOAD     = 3'd2,
      RELOAD_TURNAROUND = 3'd3,
      FLUSH_CACHE       = 3'd4,
      WAIT_FOR_NOT_FULL = 3'd5
   } state_t;

endpackage

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_queue #(parameter LG_DEPTH = `LG_FQ_ENTRIES)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               clear,
   input  logic               push,
   input  logic [`INSN_W-1:0] push_data,
   input  logic [`ADDR_W-1:0] push_pc,
   input  logic               push_pred,
   input  logic [`ADDR_W-1:0] push_target,
   input  logic               pop,
   output logic               full,
   output logic               valid,
   output logic [`INSN_W-1:0] data,
   output logic [`ADDR_W-1:0] pc,
   output logic               pred,
   output logic [`ADDR_W-1:0] target
);

   localparam DEPTH = 1 << LG_DEPTH;

   logic [`INSN_W-1:0] data_q [DEPTH];
   logic [`ADDR_W-1:0] pc_q [DEPTH];
   logic [DEPTH-1:0]   pred_q;
   logic [`ADDR_W-1:0] target_q [DEPTH];
   logic [LG_DEPTH:0]  head;    // extra bit tells full from empty
   logic [LG_DEPTH:0]  tail;

   assign valid = (head != tail);
   assign full = (head[LG_DEPTH] != tail[LG_DEPTH]) &&
                 (head[LG_DEPTH-1:0] == tail[LG_DEPTH-1:0]);

   assign data = data_q[head[LG_DEPTH-1:0]];
   assign pc = pc_q[head[LG_DEPTH-1:0]];
   assign pred = pred_q[head[LG_DEPTH-1:0]];
   assign target = target_q[head[LG_DEPTH-1:0]];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         if (push)
         begin
            tail <= tail + 1'b1;
         end
         if (pop)
         begin
            head <= head + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         data_q[tail[LG_DEPTH-1:0]] <= push_data;
         pc_q[tail[LG_DEPTH-1:0]] <= push_pc;
         pred_q[tail[LG_DEPTH-1:0]] <= push_pred;
         target_q[tail[LG_DEPTH-1:0]] <= push_target;
      end
   end

endmodule

//--- verilog/l1i_arrays.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1i_arrays import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`L1I_LG_SETS-1:0]  rd_idx,
   input  logic                     refill_en,
   input  logic [`ADDR_W-1:0]       refill_addr,
   input  logic [`L1I_CL_BITS-1:0]  refill_data,
   input  logic                     inv_en,
   input  logic [`L1I_LG_SETS-1:0]  inv_idx,
   output logic                     rd_valid,
   output logic [`L1I_TAG_W-1:0]    rd_tag,
   output logic [`L1I_CL_BITS-1:0]  rd_line,
   output jump_t [3:0]              rd_cls
);

   localparam NUM_SETS = 1 << `L1I_LG_SETS;
   localparam WORDS = `L1I_CL_BITS / `INSN_W;
   localparam IDX_LO = `L1I_LG_CL_BYTES;
   localparam IDX_HI = `L1I_LG_CL_BYTES + `L1I_LG_SETS;

   logic [NUM_SETS-1:0]     valid_arr;
   logic [`L1I_TAG_W-1:0]   tag_arr [NUM_SETS];
   logic [`L1I_CL_BITS-1:0] line_arr [NUM_SETS];
   jump_t [3:0]             cls_arr [NUM_SETS];
   logic [`L1I_CL_BITS-1:0] swapped;
   jump_t [3:0]             refill_cls;
   logic [`L1I_LG_SETS-1:0] refill_idx;

   assign refill_idx = refill_addr[IDX_HI-1:IDX_LO];

   // memory lanes arrive big-endian
   genvar k;
   generate
      for (k = 0; k < WORDS; k++)
      begin : g_word
         assign swapped[k*`INSN_W +: `INSN_W] = {refill_data[k*`INSN_W +: 8],
                                                 refill_data[k*`INSN_W+8 +: 8],
                                                 refill_data[k*`INSN_W+16 +: 8],
                                                 refill_data[k*`INSN_W+24 +: 8]};
         predecode pd (.insn(swapped[k*`INSN_W +: `INSN_W]), .cls(refill_cls[k]));
      end
   endgenerate

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_arr <= '0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (refill_en)
         begin
            valid_arr[refill_idx] <= 1'b1;
         end
         if (inv_en)
         begin
            valid_arr[inv_idx] <= 1'b0;   // flush walk
         end
         rd_valid <= valid_arr[rd_idx];
      end
   end

   always_ff @(posedge clk)
   begin
      if (refill_en)
      begin
         tag_arr[refill_idx] <= refill_addr[`ADDR_W-1:IDX_HI];
         line_arr[refill_idx] <= swapped;
         cls_arr[refill_idx] <= refill_cls;
      end
      rd_tag <= tag_arr[rd_idx];
      rd_line <= line_arr[rd_idx];
      rd_cls <= cls_arr[rd_idx];
   end

endmodule

//--- verilog/l1i_fetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module l1i_fetch import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     restart_valid,
   input  logic [`ADDR_W-1:0]       restart_pc,
   input  logic                     flush_req,
   input  logic                     mem_rsp_valid,
   input  logic [`L1I_CL_BITS-1:0]  mem_rsp_load_data,
   input  logic                     insn_ack,
   output logic                     restart_ack,
   output logic                     flush_complete,
   output logic                     mem_req_valid,
   output logic [`ADDR_W-1:0]       mem_req_addr,
   output logic                     insn_valid,
   output logic [`INSN_W-1:0]       insn_data,
   output logic [`ADDR_W-1:0]       insn_pc,
   output logic                     insn_pred,
   output logic [`ADDR_W-1:0]       insn_pred_target
);

   logic [`L1I_LG_SETS-1:0] rd_idx;
   logic                    rd_valid;
   logic [`L1I_TAG_W-1:0]   rd_tag;
   logic [`L1I_CL_BITS-1:0] rd_line;
   jump_t [3:0]             rd_cls;
   logic                    inv_en;
   logic [`L1I_LG_SETS-1:0] inv_idx;
   logic                    fq_full, fq_clear, fq_push;
   logic [`INSN_W-1:0]      push_data;
   logic [`ADDR_W-1:0]      push_pc;
   logic                    push_pred;
   logic [`ADDR_W-1:0]      push_target;

   fetch_ctrl ctrl
   (
      .clk(clk), .reset(reset),
      .restart_valid(restart_valid), .restart_pc(restart_pc), .flush_req(flush_req),
      .mem_rsp_valid(mem_rsp_valid),
      .rd_valid(rd_valid), .rd_tag(rd_tag), .rd_line(rd_line), .rd_cls(rd_cls),
      .fq_full(fq_full),
      .restart_ack(restart_ack), .flush_complete(flush_complete),
      .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
      .rd_idx(rd_idx), .inv_en(inv_en), .inv_idx(inv_idx),
      .fq_clear(fq_clear), .fq_push(fq_push),
      .push_data(push_data), .push_pc(push_pc),
      .push_pred(push_pred), .push_target(push_target)
   );

   // refill lands at the line the controller asked for
   l1i_arrays arrays
   (
      .clk(clk), .reset(reset), .rd_idx(rd_idx),
      .refill_en(mem_rsp_valid), .refill_addr(mem_req_addr),
      .refill_data(mem_rsp_load_data),
      .inv_en(inv_en), .inv_idx(inv_idx),
      .rd_valid(rd_valid), .rd_tag(rd_tag), .rd_line(rd_line), .rd_cls(rd_cls)
   );

   fetch_queue fq
   (
      .clk(clk), .reset(reset), .clear(fq_clear),
      .push(fq_push), .push_data(push_data), .push_pc(push_pc),
      .push_pred(push_pred), .push_target(push_target),
      .pop(insn_ack),
      .full(fq_full), .valid(insn_valid), .data(insn_data), .pc(insn_pc),
      .pred(insn_pred), .target(insn_pred_target)
   );

endmodule

//--- verilog/predecode.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module predecode import fetch_pkg::*;
(
   input  logic [`INSN_W-1:0] insn,
   output jump_t              cls
);

   logic [5:0] opcode;
   logic [4:0] rs;
   logic [4:0] rt;

   assign opcode = insn[31:26];
   assign rs     = insn[25:21];
   assign rt     = insn[20:16];

   // conditional branches and jr fall through as plain code
   always_comb
   begin
      case (opcode)
         6'd2:
         begin
            cls = IS_J;
         end
         6'd3:
         begin
            cls = IS_JAL;
         end
         6'd4:
         begin
            // only beq $0,$0 is always taken
            if ((rs == 5'd0) && (rt == 5'd0))
            begin
               cls = IS_BR;
            end
            else
            begin
               cls = NOT_CFLOW;
            end
         end
         default:
         begin
            cls = NOT_CFLOW;
         end
      endcase
   end

endmodule
